// File: dv/hazardCtrlTb.sv
`include "hazard_defs.svh"

module hazardCtrlTb;
	timeunit 1ns;
	timeprecision 100ps;
	import hazardPkg::*;

	localparam int RESET_CYCLES = 5;
	localparam int DIRECTED_CYCLES = 40;
	localparam int RANDOM_COUNT = 400;
	// Up to three cycles per random instruction and three for the final flush
	localparam int RANDOM_CYCLES = RANDOM_COUNT * 3 + 3;
	localparam int TEST_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES;

	// Random stream draws from the first twelve instruction kinds
	localparam int K_RALU = 0;
	localparam int K_MULDIV = 1;
	localparam int K_MFHILO = 2;
	localparam int K_MTHILO = 3;
	localparam int K_JR = 4;
	localparam int K_IMM = 5;
	localparam int K_LUI = 6;
	localparam int K_LOAD = 7;
	localparam int K_STORE = 8;
	localparam int K_J = 9;
	localparam int K_JAL = 10;
	localparam int K_MSUB = 11;
	localparam int K_NOP = 12;

	localparam logic [0:5][5:0] ALU_FN = {`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT, `FN_SLTU};
	localparam logic [0:3][5:0] MD_FN = {`FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU};
	localparam logic [0:3][5:0] HILO_FN = {`FN_MFHI, `FN_MFLO, `FN_MTHI, `FN_MTLO};
	localparam logic [0:2][5:0] IMM_OP = {`OP_ORI, `OP_ADDI, `OP_ANDI};
	localparam logic [0:2][5:0] LOAD_OP = {`OP_LW, `OP_LB, `OP_LH};
	localparam logic [0:2][5:0] STORE_OP = {`OP_SW, `OP_SB, `OP_SH};

	logic     clk;
	logic     rstN;
	instrWord instrD;
	logic     stall;
	fwdSel    fwdRs;
	fwdSel    fwdRt;

	// Expected record of the instruction held in D
	regNum  curDst;
	tCycles curTnew;
	regNum  curSrc [2];
	tCycles curTuse [2];

	// Shadow producers with E at index 0
	regNum  shDst [3];
	tCycles shTnew [3];

	logic  expStall;
	fwdSel expFwdRs;
	fwdSel expFwdRt;
	int    errCount = 0;
	int    errAtStart = 0;
	int    okTests = 0;
	int    badTests = 0;
	logic [31:0] rnd;

	hazardCtrl i_hazardCtrl (
		.clk(clk), .rstN(rstN), .instrD(instrD), .stall(stall), .fwdRs(fwdRs), .fwdRt(fwdRt)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////
	// Shadow model
	////////////////////////////////////////
	always @(posedge clk) begin
		if (!rstN) begin
			for (int s = 0; s < 3; s++) begin
				shDst[s]  <= '0;
				shTnew[s] <= '0;
			end
		end else begin
			shDst[0]  <= expStall ? regNum'(0) : curDst;
			shTnew[0] <= expStall ? tCycles'(0) : curTnew;
			for (int s = 1; s < 3; s++) begin
				shDst[s]  <= shDst[s - 1];
				shTnew[s] <= (shTnew[s - 1] == '0) ? tCycles'(0) : tCycles'(shTnew[s - 1] - 1);
			end
		end
	end

	always_comb begin
		fwdSel sel [2];
		logic  found;
		expStall = 1'b0;
		for (int i = 0; i < 2; i++) begin
			sel[i] = `FWD_NONE;
			found = 1'b0;
			// Walk from E to W so the first hit is the youngest producer
			for (int s = 0; s < 3; s++) begin
				if (!found && curSrc[i] != '0 && shDst[s] == curSrc[i]) begin
					found = 1'b1;
					if (shTnew[s] > curTuse[i])
						expStall = 1'b1;
					if (shTnew[s] == '0)
						sel[i] = fwdSel'(s + 1);
				end
			end
		end
		expFwdRs = sel[0];
		expFwdRt = sel[1];
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////
	aResetQuiet: assert property (@(posedge clk)
		!rstN |-> (!stall && fwdRs == `FWD_NONE && fwdRt == `FWD_NONE))
	else begin
		errCount++;
		$display("error at %0t: stall or forward active during reset", $time);
	end

	aStall: assert property (@(posedge clk) disable iff (!rstN) stall == expStall)
	else begin
		errCount++;
		$display("error at %0t: stall is %0b, expected %0b", $time,
			$sampled(stall), $sampled(expStall));
	end

	aFwdRs: assert property (@(posedge clk) disable iff (!rstN) fwdRs == expFwdRs)
	else begin
		errCount++;
		$display("error at %0t: fwdRs is %0d, expected %0d", $time,
			$sampled(fwdRs), $sampled(expFwdRs));
	end

	aFwdRt: assert property (@(posedge clk) disable iff (!rstN) fwdRt == expFwdRt)
	else begin
		errCount++;
		$display("error at %0t: fwdRt is %0d, expected %0d", $time,
			$sampled(fwdRt), $sampled(expFwdRt));
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic logic [5:0] pickCode(input int kind, input logic [7:0] sel);
		case (kind)
			K_RALU: return ALU_FN[sel % 6];
			K_MULDIV: return MD_FN[sel % 4];
			K_MFHILO: return HILO_FN[sel % 2];
			K_MTHILO: return HILO_FN[2 + sel % 2];
			K_IMM: return IMM_OP[sel % 3];
			K_LOAD: return LOAD_OP[sel % 3];
			K_STORE: return STORE_OP[sel % 3];
			default: return 6'd0;
		endcase
	endfunction

	task automatic setExpected(input regNum dst, input tCycles tnew, input regNum s0,
		input tCycles u0, input regNum s1, input tCycles u1);
		curDst = dst;
		curTnew = tnew;
		curSrc[0] = s0;
		curTuse[0] = u0;
		curSrc[1] = s1;
		curTuse[1] = u1;
	endtask

	// Drives one instruction into D and waits until it leaves D
	task automatic issue(input int kind, input logic [5:0] code, input regNum rs,
		input regNum rt, input regNum rd);
		instrWord w;
		logic     held;
		case (kind)
			K_RALU, K_MULDIV: begin
				w = {`OP_R, rs, rt, rd, 5'd0, code};
				setExpected((kind == K_RALU) ? rd : 5'd0, 2'd1, rs, 2'd1, rt, 2'd1);
			end
			K_MSUB: begin
				w = {`OP_MSUB, rs, rt, rd, 5'd0, 6'd4};
				setExpected(5'd0, 2'd1, rs, 2'd1, rt, 2'd1);
			end
			K_MFHILO: begin
				w = {`OP_R, 10'd0, rd, 5'd0, code};
				setExpected(rd, 2'd1, 5'd0, `TUSE_NONE, 5'd0, `TUSE_NONE);
			end
			K_MTHILO, K_JR: begin
				w = {`OP_R, rs, 15'd0, (kind == K_JR) ? `FN_JR : code};
				setExpected(5'd0, 2'd0, rs, (kind == K_JR) ? 2'd0 : 2'd1, 5'd0, `TUSE_NONE);
			end
			K_IMM, K_LOAD: begin
				w = {code, rs, rt, 16'h0010};
				setExpected(rt, (kind == K_LOAD) ? 2'd2 : 2'd1, rs, 2'd1, 5'd0, `TUSE_NONE);
			end
			K_LUI: begin
				w = {`OP_LUI, 5'd0, rt, 16'h0010};
				setExpected(rt, 2'd1, 5'd0, `TUSE_NONE, 5'd0, `TUSE_NONE);
			end
			K_STORE: begin
				w = {code, rs, rt, 16'h0010};
				setExpected(5'd0, 2'd0, rs, 2'd1, rt, 2'd2);
			end
			K_J, K_JAL: begin
				w = {(kind == K_JAL) ? `OP_JAL : `OP_J, rs, rt, 16'h0040};
				setExpected((kind == K_JAL) ? 5'd31 : 5'd0, 2'd0,
					5'd0, `TUSE_NONE, 5'd0, `TUSE_NONE);
			end
			default: begin
				w = '0;
				setExpected(5'd0, 2'd0, 5'd0, `TUSE_NONE, 5'd0, `TUSE_NONE);
			end
		endcase
		instrD = w;
		do begin
			@(negedge clk);
			held = stall;
			@(posedge clk);
			#10;
		end while (held);
	endtask

	task automatic flush();
		repeat (3) issue(K_NOP, 6'd0, 5'd0, 5'd0, 5'd0);
	endtask

	task automatic endTest(input string name);
		if (errCount == errAtStart) begin
			okTests++;
			$display("%s: ok", name);
		end else begin
			badTests++;
			$display("%s: %0d errors", name, errCount - errAtStart);
		end
		errAtStart = errCount;
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////
	initial begin
		int kind;
		rstN = 1'b0;
		// A self-dependent load in D stays quiet only while E is empty
		instrD = {`OP_LW, 5'd3, 5'd3, 16'h0010};
		setExpected(5'd3, 2'd2, 5'd3, 2'd1, 5'd0, `TUSE_NONE);
		rnd = 32'h4fa0_5f1c;
		repeat (RESET_CYCLES) @(posedge clk);
		#10;
		rstN = 1'b1;
		@(posedge clk);
		#10;
		endTest("reset");

		// Second reader of $2 sees it in M
		issue(K_IMM, `OP_ADDI, 5'd0, 5'd2, 5'd0);
		issue(K_RALU, `FN_ADD, 5'd2, 5'd1, 5'd5);
		issue(K_RALU, `FN_OR, 5'd2, 5'd0, 5'd6);
		flush();
		endTest("alu chain");

		issue(K_LOAD, `OP_LW, 5'd0, 5'd3, 5'd0);
		issue(K_RALU, `FN_SUB, 5'd3, 5'd1, 5'd7);
		flush();
		endTest("load use");

		issue(K_LOAD, `OP_LW, 5'd0, 5'd4, 5'd0);
		issue(K_STORE, `OP_SW, 5'd1, 5'd4, 5'd0);
		flush();
		endTest("store data");

		// Then a load to $0 that must never match
		issue(K_JAL, 6'd0, 5'd0, 5'd0, 5'd0);
		issue(K_JR, 6'd0, 5'd31, 5'd0, 5'd0);
		issue(K_LOAD, `OP_LW, 5'd1, 5'd0, 5'd0);
		issue(K_RALU, `FN_ADD, 5'd0, 5'd0, 5'd8);
		flush();
		endTest("jump and link");

		repeat (RANDOM_COUNT) begin
			rnd = xorshift(rnd);
			kind = rnd % 12;
			issue(kind, pickCode(kind, rnd[15:8]), {2'b00, rnd[18:16]},
				{2'b00, rnd[21:19]}, {2'b00, rnd[24:22]});
		end
		flush();
		endTest("random stream");

		$display("tests ok: %0d, tests with errors: %0d", okTests, badTests);
		if (badTests == 0 && errCount == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		#((TEST_CYCLES + 100) * 100);
		$display("The run timed out before all tests finished");
		$display("Test failed");
		$finish;
	end

endmodule

// File: list.f
+incdir+logic
logic/hazardPkg.sv
logic/newDecoder.sv
logic/useDecoder.sv
logic/stageTracker.sv
logic/hazardResolver.sv
logic/hazardCtrl.sv
dv/hazardCtrlTb.sv

// File: logic/hazardCtrl.sv
module hazardCtrl (
	input  logic                clk,
	input  logic                rstN,
	input  hazardPkg::instrWord instrD,
	output logic                stall,
	output hazardPkg::fwdSel    fwdRs,
	output hazardPkg::fwdSel    fwdRt
);
	import hazardPkg::*;

	// Decoded record of the instruction in D
	tCycles newTnew;
	regNum  newDst;
	regNum  rsNum;
	regNum  rtNum;
	tCycles rsTuse;
	tCycles rtTuse;

	// Tracked producers
	regNum  dstE, dstM, dstW;
	tCycles tnewE, tnewM, tnewW;

	newDecoder i_newDecoder (.instr(instrD), .tnew(newTnew), .dst(newDst));

	useDecoder i_useDecoder (
		.instr(instrD), .rsNum(rsNum), .rtNum(rtNum), .rsTuse(rsTuse), .rtTuse(rtTuse)
	);

	stageTracker i_stageTracker (
		.clk(clk), .rstN(rstN), .stall(stall), .newTnew(newTnew), .newDst(newDst),
		.dstE(dstE), .dstM(dstM), .dstW(dstW), .tnewE(tnewE), .tnewM(tnewM), .tnewW(tnewW)
	);

	hazardResolver i_hazardResolver (
		.rsNum(rsNum), .rtNum(rtNum), .rsTuse(rsTuse), .rtTuse(rtTuse),
		.dstE(dstE), .dstM(dstM), .dstW(dstW), .tnewE(tnewE), .tnewM(tnewM), .tnewW(tnewW),
		.stall(stall), .fwdRs(fwdRs), .fwdRt(fwdRt)
	);

endmodule

// File: logic/hazardPkg.sv
package hazardPkg;

	// Raw instruction as held in decode
	typedef logic [31:0] instrWord;

	// Register number, 0 stands for no register
	typedef logic [4:0] regNum;

	// Stage count, used for both Tnew and Tuse
	typedef logic [1:0] tCycles;

	// Forward source code
	typedef logic [1:0] fwdSel;

endpackage

// File: logic/hazardResolver.sv
`include "hazard_defs.svh"

module hazardResolver (
	input  hazardPkg::regNum  rsNum,
	input  hazardPkg::regNum  rtNum,
	input  hazardPkg::tCycles rsTuse,
	input  hazardPkg::tCycles rtTuse,
	input  hazardPkg::regNum  dstE,
	input  hazardPkg::regNum  dstM,
	input  hazardPkg::regNum  dstW,
	input  hazardPkg::tCycles tnewE,
	input  hazardPkg::tCycles tnewM,
	input  hazardPkg::tCycles tnewW,
	output logic              stall,
	output hazardPkg::fwdSel  fwdRs,
	output hazardPkg::fwdSel  fwdRt
);
	import hazardPkg::*;

	logic rsStall;
	logic rtStall;

	// Returns {stall, select} for one source; youngest stage wins
	function automatic logic [2:0] resolve(
		input regNum  src,
		input tCycles tuse,
		input regNum  dE, input tCycles tE,
		input regNum  dM, input tCycles tM,
		input regNum  dW, input tCycles tW
	);
		logic   hit;
		tCycles tnew;
		fwdSel  code;
		hit  = 1'b1;
		tnew = '0;
		code = `FWD_NONE;
		if (src != '0 && src == dE) begin
			tnew = tE;
			code = `FWD_E;
		end else if (src != '0 && src == dM) begin
			tnew = tM;
			code = `FWD_M;
		end else if (src != '0 && src == dW) begin
			tnew = tW;
			code = `FWD_W;
		end else begin
			hit = 1'b0;
		end
		return {hit && (tnew > tuse), (hit && tnew == '0) ? code : fwdSel'(`FWD_NONE)};
	endfunction

	assign {rsStall, fwdRs} = resolve(rsNum, rsTuse, dstE, tnewE, dstM, tnewM, dstW, tnewW);
	assign {rtStall, fwdRt} = resolve(rtNum, rtTuse, dstE, tnewE, dstM, tnewM, dstW, tnewW);

	assign stall = rsStall | rtStall;

	// A stalling source must never be handed a forwarded value
	always_comb begin
		aNoFwdOnStall: assert final (!stall
			|| ((!rsStall || fwdRs == `FWD_NONE) && (!rtStall || fwdRt == `FWD_NONE)))
		else $error("%0t: forward select active on a stalling source", $time);
	end

endmodule

// File: logic/hazard_defs.svh
`ifndef HAZARD_DEFS_SVH
`define HAZARD_DEFS_SVH

////////////////////////////////////////
// Primary opcodes, instr[31:26]
////////////////////////////////////////
`define OP_R     6'b000000
`define OP_J     6'b000010
`define OP_JAL   6'b000011
`define OP_ADDI  6'b001000
`define OP_ANDI  6'b001100
`define OP_ORI   6'b001101
`define OP_LUI   6'b001111
`define OP_MSUB  6'b011100
`define OP_LB    6'b100000
`define OP_LH    6'b100001
`define OP_LW    6'b100011
`define OP_SB    6'b101000
`define OP_SH    6'b101001
`define OP_SW    6'b101011

////////////////////////////////////////
// R-type function codes, instr[5:0]
////////////////////////////////////////
`define FN_JR    6'b001000
`define FN_MFHI  6'b010000
`define FN_MTHI  6'b010001
`define FN_MFLO  6'b010010
`define FN_MTLO  6'b010011
`define FN_MULT  6'b011000
`define FN_MULTU 6'b011001
`define FN_DIV   6'b011010
`define FN_DIVU  6'b011011
`define FN_ADD   6'b100000
`define FN_SUB   6'b100010
`define FN_AND   6'b100100
`define FN_OR    6'b100101
`define FN_SLT   6'b101010
`define FN_SLTU  6'b101011

// Operand never read, larger than any Tnew
`define TUSE_NONE 2'd3

////////////////////////////////////////
// Forward source selects
////////////////////////////////////////
`define FWD_NONE 2'd0
`define FWD_E    2'd1
`define FWD_M    2'd2
`define FWD_W    2'd3

`endif

// File: logic/newDecoder.sv
`include "hazard_defs.svh"

module newDecoder (
	input  hazardPkg::instrWord instr,
	output hazardPkg::tCycles   tnew,
	output hazardPkg::regNum    dst
);
	import hazardPkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	regNum      rt;
	regNum      rd;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];

	always_comb begin
		// Stores, branches and unknown codes produce nothing
		tnew = 2'd0;
		dst  = '0;
		case (opcode)
			`OP_R: begin
				case (funct)
					`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT, `FN_SLTU: begin
						tnew = 2'd1;
						dst  = rd;
					end
					`FN_MFHI, `FN_MFLO: begin
						tnew = 2'd1;
						dst  = rd;
					end
					// Result goes to HI/LO, not the register file
					`FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU: begin
						tnew = 2'd1;
						dst  = '0;
					end
					`FN_JR, `FN_MTHI, `FN_MTLO: begin
						tnew = 2'd0;
						dst  = '0;
					end
					default: begin
						tnew = 2'd0;
						dst  = '0;
					end
				endcase
			end
			`OP_ORI, `OP_ADDI, `OP_ANDI: begin
				tnew = 2'd1;
				dst  = rt;
			end
			`OP_LUI: begin
				tnew = 2'd1;
				dst  = rt;
			end
			// Load data only shows up after M
			`OP_LW, `OP_LB, `OP_LH: begin
				tnew = 2'd2;
				dst  = rt;
			end
			`OP_SW, `OP_SB, `OP_SH: begin
				tnew = 2'd0;
				dst  = '0;
			end
			// Link address is known at decode already
			`OP_JAL: begin
				tnew = 2'd0;
				dst  = 5'd31;
			end
			`OP_J: begin
				tnew = 2'd0;
				dst  = '0;
			end
			`OP_MSUB: begin
				tnew = 2'd1;
				dst  = '0;
			end
			default: begin
				tnew = 2'd0;
				dst  = '0;
			end
		endcase
	end

endmodule

// File: logic/stageTracker.sv
module stageTracker (
	input  logic              clk,
	input  logic              rstN,
	input  logic              stall,
	input  hazardPkg::tCycles newTnew,
	input  hazardPkg::regNum  newDst,
	output hazardPkg::regNum  dstE,
	output hazardPkg::regNum  dstM,
	output hazardPkg::regNum  dstW,
	output hazardPkg::tCycles tnewE,
	output hazardPkg::tCycles tnewM,
	output hazardPkg::tCycles tnewW
);
	import hazardPkg::*;

	// One stage closer to ready, never below zero
	function automatic tCycles countDown(input tCycles t);
		return (t == 2'd0) ? 2'd0 : t - 2'd1;
	endfunction

	////////////////////////////////////////
	// Producer records behind D
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rstN) begin
			dstE  <= '0;
			tnewE <= '0;
			dstM  <= '0;
			tnewM <= '0;
			dstW  <= '0;
			tnewW <= '0;
		end else begin
			// Bubble into E while D is held
			dstE  <= stall ? regNum'(0) : newDst;
			tnewE <= stall ? tCycles'(0) : newTnew;
			dstM  <= dstE;
			tnewM <= countDown(tnewE);
			dstW  <= dstM;
			tnewW <= countDown(tnewM);
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////
	aBubbleAfterStall: assert property (
		@(posedge clk) disable iff (!rstN) stall |=> (dstE == '0)
	) else $error("%0t: no bubble in E after a stall", $time);

	// Even a load has counted down by the time it reaches W
	aReadyInW: assert property (
		@(posedge clk) disable iff (!rstN) tnewW == '0
	) else $error("%0t: W record still pending", $time);

endmodule

// File: logic/useDecoder.sv
`include "hazard_defs.svh"

module useDecoder (
	input  hazardPkg::instrWord instr,
	output hazardPkg::regNum    rsNum,
	output hazardPkg::regNum    rtNum,
	output hazardPkg::tCycles   rsTuse,
	output hazardPkg::tCycles   rtTuse
);
	import hazardPkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	regNum      rs;
	regNum      rt;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];

	always_comb begin
		// Unread fields never match a producer
		rsNum  = '0;
		rtNum  = '0;
		rsTuse = `TUSE_NONE;
		rtTuse = `TUSE_NONE;
		case (opcode)
			`OP_R: begin
				case (funct)
					// Jump target is needed right in D
					`FN_JR: begin
						rsNum  = rs;
						rsTuse = 2'd0;
					end
					`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT, `FN_SLTU,
					`FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU: begin
						rsNum  = rs;
						rsTuse = 2'd1;
						rtNum  = rt;
						rtTuse = 2'd1;
					end
					`FN_MTHI, `FN_MTLO: begin
						rsNum  = rs;
						rsTuse = 2'd1;
					end
					default: begin
						rsNum = '0;
						rtNum = '0;
					end
				endcase
			end
			`OP_MSUB: begin
				rsNum  = rs;
				rsTuse = 2'd1;
				rtNum  = rt;
				rtTuse = 2'd1;
			end
			`OP_ORI, `OP_ADDI, `OP_ANDI, `OP_LW, `OP_LB, `OP_LH: begin
				rsNum  = rs;
				rsTuse = 2'd1;
			end
			// Base address in E, store data not before M
			`OP_SW, `OP_SB, `OP_SH: begin
				rsNum  = rs;
				rsTuse = 2'd1;
				rtNum  = rt;
				rtTuse = 2'd2;
			end
			default: begin
				rsNum = '0;
				rtNum = '0;
			end
		endcase
	end

endmodule
